// ==== rtl/tag_pkg.sv ====
package tag_pkg;

    // bank and slot geometry.
    localparam int NUM_BANKS = 4;
    localparam int BANK_BITS = $clog2(NUM_BANKS);
    localparam int SLOTS     = 8;
    localparam int SLOT_BITS = $clog2(SLOTS);

    localparam int TAG_W = BANK_BITS + SLOT_BITS;

    // bank sits in the upper bits, slot in the lower bits.
    typedef struct packed {
        logic [BANK_BITS-1:0] bank;
        logic [SLOT_BITS-1:0] slot;
    } tag_fields_t;

    // memory tag, seen either as one word or as bank and slot.
    typedef union packed {
        logic [TAG_W-1:0] raw;
        tag_fields_t      fields;
    } mem_tag_t;

endpackage

// ==== rtl/slot_picker.sv ====
`timescale 1ns/1ps

module slot_picker #(
    parameter int N = 8
) (
    input  logic [N-1:0]         in,
    output logic [$clog2(N)-1:0] index,
    output logic                 valid
);

    localparam int IDX_W = $clog2(N);

    // scan from the top so the lowest set bit wins.
    always_comb begin
        index = '0;
        valid = 1'b0;
        for (int i = N - 1; i >= 0; i--) begin
            if (in[i]) begin
                index = IDX_W'(i);
                valid = 1'b1;
            end
        end
    end

endmodule

// ==== rtl/meta_ram.sv ====
`timescale 1ns/1ps

module meta_ram #(
    parameter int META_W = 8
) (
    input  logic                          clk,
    input  logic                          wren,
    input  logic [tag_pkg::SLOT_BITS-1:0] waddr,
    input  logic [META_W-1:0]             wdata,
    input  logic [tag_pkg::SLOT_BITS-1:0] raddr,
    output logic [META_W-1:0]             rdata
);

    import tag_pkg::*;

    logic [META_W-1:0] mem [SLOTS];

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr]; // asynchronous read.

endmodule

// ==== rtl/index_buffer.sv ====
`timescale 1ns/1ps

module index_buffer #(
    parameter int META_W = 8
) (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          acquire,
    input  logic [META_W-1:0]             acquire_meta,
    output logic [tag_pkg::SLOT_BITS-1:0] write_slot,

    input  logic                          release_slot,
    input  logic [tag_pkg::SLOT_BITS-1:0] release_addr,
    output logic [META_W-1:0]             read_meta,

    output logic                          empty,
    output logic                          full
);

    import tag_pkg::*;

    logic [SLOTS-1:0]     free_slots;   // one bit per slot, set when free.
    logic [SLOTS-1:0]     free_slots_n;
    logic [SLOT_BITS-1:0] free_index;
    logic                 free_valid;

    // bitmap after this cycle's release and acquire.
    always_comb begin
        free_slots_n = free_slots;
        if (release_slot) begin
            free_slots_n[release_addr] = 1'b1;
        end
        if (acquire) begin
            free_slots_n[write_slot] = 1'b0;
        end
    end

    slot_picker #(
        .N (SLOTS)
    ) picker (
        .in    (free_slots_n),
        .index (free_index),
        .valid (free_valid)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            free_slots <= '1;
            write_slot <= '0;
            empty      <= 1'b1;
            full       <= 1'b0;
        end else begin
            free_slots <= free_slots_n;
            write_slot <= free_index;
            empty      <= &free_slots_n;
            full       <= ~free_valid; // no free slot left.
        end
    end

    // metadata lands in the slot handed out this cycle.
    meta_ram #(
        .META_W (META_W)
    ) ram (
        .clk   (clk),
        .wren  (acquire),
        .waddr (write_slot),
        .wdata (acquire_meta),
        .raddr (release_addr),
        .rdata (read_meta)
    );

endmodule

// ==== rtl/req_dispatch.sv ====
`timescale 1ns/1ps

module req_dispatch #(
    parameter int META_W = 8,
    parameter int ADDR_W = 16
) (
    input  logic                                           clk,
    input  logic                                           reset,

    input  logic                                           req_valid,
    input  logic [ADDR_W-1:0]                              req_addr,
    input  logic [META_W-1:0]                              req_meta,

    input  logic [tag_pkg::NUM_BANKS-1:0]                  bank_full,
    input  logic [tag_pkg::NUM_BANKS*tag_pkg::SLOT_BITS-1:0] write_slot,
    output logic [tag_pkg::NUM_BANKS-1:0]                  acquire,
    output logic [META_W-1:0]                              acquire_meta,

    output logic                                           req_drop,
    output logic                                           mem_req_valid,
    output logic [ADDR_W-1:0]                              mem_req_addr,
    output tag_pkg::mem_tag_t                              mem_req_tag
);

    import tag_pkg::*;

    logic [BANK_BITS-1:0] bank;
    logic                 accept;
    mem_tag_t             tag_n;

    assign bank   = req_addr[BANK_BITS-1:0]; // low address bits pick the bank.
    assign accept = req_valid && !bank_full[bank];

    always_comb begin
        acquire = '0;
        if (accept) begin
            acquire[bank] = 1'b1;
        end
    end

    assign acquire_meta = req_meta;

    always_comb begin
        tag_n.fields.bank = bank;
        tag_n.fields.slot = write_slot[bank*SLOT_BITS +: SLOT_BITS];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_req_valid <= 1'b0;
            req_drop      <= 1'b0;
        end else begin
            mem_req_valid <= accept;
            req_drop      <= req_valid && bank_full[bank]; // full bank, request is lost.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem_req_addr <= req_addr;
            mem_req_tag  <= tag_n;
        end
    end

endmodule

// ==== rtl/rsp_collect.sv ====
`timescale 1ns/1ps

module rsp_collect #(
    parameter int META_W = 8,
    parameter int DATA_W = 32
) (
    input  logic                                     clk,
    input  logic                                     reset,

    input  logic                                     mem_rsp_valid,
    input  tag_pkg::mem_tag_t                        mem_rsp_tag,
    input  logic [DATA_W-1:0]                        mem_rsp_data,

    input  logic [tag_pkg::NUM_BANKS*META_W-1:0]     read_meta,
    output logic [tag_pkg::NUM_BANKS-1:0]            release_slot,
    output logic [tag_pkg::SLOT_BITS-1:0]            release_addr,

    output logic                                     rsp_valid,
    output logic [META_W-1:0]                        rsp_meta,
    output logic [DATA_W-1:0]                        rsp_data
);

    import tag_pkg::*;

    logic [BANK_BITS-1:0] bank;
    logic [META_W-1:0]    bank_meta;

    assign bank         = mem_rsp_tag.fields.bank;
    assign release_addr = mem_rsp_tag.fields.slot; // also the ram read address.

    always_comb begin
        release_slot = '0;
        if (mem_rsp_valid) begin
            release_slot[bank] = 1'b1;
        end
    end

    // metadata of the answering bank, read in the same cycle.
    assign bank_meta = read_meta[bank*META_W +: META_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= mem_rsp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_rsp_valid) begin
            rsp_meta <= bank_meta;
            rsp_data <= mem_rsp_data;
        end
    end

endmodule

// ==== rtl/tag_tracker.sv ====
`timescale 1ns/1ps

module tag_tracker #(
    parameter int META_W = 8,
    parameter int ADDR_W = 16,
    parameter int DATA_W = 32
) (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          req_valid,
    input  logic [ADDR_W-1:0]             req_addr,
    input  logic [META_W-1:0]             req_meta,
    output logic                          req_drop,

    output logic                          mem_req_valid,
    output logic [ADDR_W-1:0]             mem_req_addr,
    output tag_pkg::mem_tag_t             mem_req_tag,

    input  logic                          mem_rsp_valid,
    input  tag_pkg::mem_tag_t             mem_rsp_tag,
    input  logic [DATA_W-1:0]             mem_rsp_data,

    output logic                          rsp_valid,
    output logic [META_W-1:0]             rsp_meta,
    output logic [DATA_W-1:0]             rsp_data,

    output logic [tag_pkg::NUM_BANKS-1:0] bank_full,
    output logic                          idle
);

    import tag_pkg::*;

    logic [NUM_BANKS-1:0]           acquire;
    logic [META_W-1:0]              acquire_meta;
    logic [NUM_BANKS*SLOT_BITS-1:0] write_slot;
    logic [NUM_BANKS-1:0]           release_slot;
    logic [SLOT_BITS-1:0]           release_addr;
    logic [NUM_BANKS*META_W-1:0]    read_meta;
    logic [NUM_BANKS-1:0]           bank_empty;

    req_dispatch #(
        .META_W (META_W),
        .ADDR_W (ADDR_W)
    ) dispatch (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .req_meta      (req_meta),
        .bank_full     (bank_full),
        .write_slot    (write_slot),
        .acquire       (acquire),
        .acquire_meta  (acquire_meta),
        .req_drop      (req_drop),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_tag   (mem_req_tag)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        index_buffer #(
            .META_W (META_W)
        ) buffer (
            .clk          (clk),
            .reset        (reset),
            .acquire      (acquire[b]),
            .acquire_meta (acquire_meta),
            .write_slot   (write_slot[b*SLOT_BITS +: SLOT_BITS]),
            .release_slot (release_slot[b]),
            .release_addr (release_addr),
            .read_meta    (read_meta[b*META_W +: META_W]),
            .empty        (bank_empty[b]),
            .full         (bank_full[b])
        );
    end

    rsp_collect #(
        .META_W (META_W),
        .DATA_W (DATA_W)
    ) collect (
        .clk           (clk),
        .reset         (reset),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_tag   (mem_rsp_tag),
        .mem_rsp_data  (mem_rsp_data),
        .read_meta     (read_meta),
        .release_slot  (release_slot),
        .release_addr  (release_addr),
        .rsp_valid     (rsp_valid),
        .rsp_meta      (rsp_meta),
        .rsp_data      (rsp_data)
    );

    assign idle = &bank_empty; // nothing outstanding in any bank.

endmodule

// ==== sim/tb_tag_tracker.sv ====
`timescale 1ns/1ps

module tb_tag_tracker;

    import tag_pkg::*;

    localparam int META_W      = 8;
    localparam int ADDR_W      = 16;
    localparam int DATA_W      = 32;
    localparam int PERIOD      = 8;
    localparam int NUM_TAGS    = NUM_BANKS * SLOTS;
    localparam int RAND_CYCLES = 300;
    localparam int TEST_CYCLES = 100 + RAND_CYCLES; // directed tests plus the random run.

    logic                 clk;
    logic                 reset;
    logic                 req_valid;
    logic [ADDR_W-1:0]    req_addr;
    logic [META_W-1:0]    req_meta;
    logic                 req_drop;
    logic                 mem_req_valid;
    logic [ADDR_W-1:0]    mem_req_addr;
    mem_tag_t             mem_req_tag;
    logic                 mem_rsp_valid;
    mem_tag_t             mem_rsp_tag;
    logic [DATA_W-1:0]    mem_rsp_data;
    logic                 rsp_valid;
    logic [META_W-1:0]    rsp_meta;
    logic [DATA_W-1:0]    rsp_data;
    logic [NUM_BANKS-1:0] bank_full;
    logic                 idle;

    // scoreboard indexed by the raw tag.
    logic                 outstanding [NUM_TAGS];
    logic [META_W-1:0]    sb_meta [NUM_TAGS];
    logic [ADDR_W-1:0]    sb_addr [NUM_TAGS];
    int                   bank_count [NUM_BANKS];
    int                   newest_tag; // issued last cycle and not yet seen by the memory.

    // what the DUT must show one cycle after the current inputs.
    logic                 exp_mem_valid;
    logic [ADDR_W-1:0]    exp_mem_addr;
    logic [TAG_W-1:0]     exp_mem_tag;
    logic                 exp_drop;
    logic                 exp_rsp_valid;
    logic [META_W-1:0]    exp_rsp_meta;
    logic [DATA_W-1:0]    exp_rsp_data;

    int                   drops;
    logic [15:0]          lfsr_state;

    tag_tracker #(
        .META_W (META_W),
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W)
    ) DUT (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .req_meta      (req_meta),
        .req_drop      (req_drop),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_tag   (mem_req_tag),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_tag   (mem_rsp_tag),
        .mem_rsp_data  (mem_rsp_data),
        .rsp_valid     (rsp_valid),
        .rsp_meta      (rsp_meta),
        .rsp_data      (rsp_data),
        .bank_full     (bank_full),
        .idle          (idle)
    );

    task automatic stop_on_failure();
        $display("*** FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
            stop_on_failure();
        end
    endtask

    // galois lfsr for x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit.
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        logic        bit_out;
        value = '0;
        for (int i = 0; i < n; i++) begin
            bit_out    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (bit_out) begin
                lfsr_state = lfsr_state ^ 16'hB400;
            end
            value = {value[30:0], bit_out};
        end
        return value;
    endfunction

    function automatic logic [DATA_W-1:0] memory_data(input int tag);
        return DATA_W'({~sb_addr[tag], sb_addr[tag]}); // modelled memory contents.
    endfunction

    function automatic int lowest_free(input int bank);
        for (int s = 0; s < SLOTS; s++) begin
            if (!outstanding[bank * SLOTS + s]) begin
                return s;
            end
        end
        return -1;
    endfunction

    function automatic int count_open();
        int n;
        n = 0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            n += bank_count[b];
        end
        return n;
    endfunction

    function automatic int count_ready();
        int n;
        n = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (outstanding[t] && t != newest_tag) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic int pick_ready(input int index);
        int n;
        n = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (outstanding[t] && t != newest_tag) begin
                if (n == index) begin
                    return t;
                end
                n++;
            end
        end
        return -1;
    endfunction

    task automatic check_outputs();
        logic [NUM_BANKS-1:0] exp_full;
        for (int b = 0; b < NUM_BANKS; b++) begin
            exp_full[b] = (bank_count[b] == SLOTS);
        end
        check_value("mem_req_valid", 32'(mem_req_valid), 32'(exp_mem_valid));
        check_value("req_drop", 32'(req_drop), 32'(exp_drop));
        check_value("rsp_valid", 32'(rsp_valid), 32'(exp_rsp_valid));
        if (exp_mem_valid) begin
            check_value("mem_req_addr", 32'(mem_req_addr), 32'(exp_mem_addr));
            check_value("mem_req_tag", 32'(mem_req_tag.raw), 32'(exp_mem_tag));
        end
        if (exp_rsp_valid) begin
            check_value("rsp_meta", 32'(rsp_meta), 32'(exp_rsp_meta));
            check_value("rsp_data", 32'(rsp_data), 32'(exp_rsp_data));
        end
        check_value("bank_full", 32'(bank_full), 32'(exp_full));
        check_value("idle", 32'(idle), 32'(count_open() == 0));
    endtask

    // one clock of stimulus that checks the previous cycle and predicts this one.
    task automatic drive_cycle(input logic do_req, input logic [ADDR_W-1:0] addr,
                               input logic [META_W-1:0] meta, input logic do_rsp,
                               input int tag);
        int                bank;
        int                slot;
        int                new_tag;
        logic [DATA_W-1:0] data;
        if (do_rsp && !outstanding[tag]) begin
            $display("a response was about to be sent for tag %0d, which is not outstanding", tag);
            stop_on_failure();
        end
        bank = int'(addr[BANK_BITS-1:0]);
        data = do_rsp ? memory_data(tag) : '0;
        @(posedge clk);
        req_valid       <= do_req;
        req_addr        <= addr;
        req_meta        <= meta;
        mem_rsp_valid   <= do_rsp;
        mem_rsp_tag.raw <= TAG_W'(tag);
        mem_rsp_data    <= data;
        @(negedge clk);
        check_outputs();
        // the request sees the bank as it was before this cycle's release.
        slot          = lowest_free(bank);
        exp_mem_valid = do_req && (bank_count[bank] < SLOTS);
        exp_drop      = do_req && (bank_count[bank] == SLOTS);
        exp_mem_addr  = addr;
        exp_mem_tag   = TAG_W'(bank * SLOTS + slot);
        exp_rsp_valid = do_rsp;
        if (do_rsp) begin
            exp_rsp_meta     = sb_meta[tag];
            exp_rsp_data     = data;
            outstanding[tag] = 1'b0;
            bank_count[tag / SLOTS]--;
        end
        newest_tag = -1;
        if (exp_mem_valid) begin
            new_tag              = bank * SLOTS + slot;
            outstanding[new_tag] = 1'b1;
            sb_meta[new_tag]     = meta;
            sb_addr[new_tag]     = addr;
            bank_count[bank]++;
            newest_tag = new_tag;
        end
        if (exp_drop) begin
            drops++;
        end
    endtask

    task automatic request(input logic [ADDR_W-1:0] addr, input logic [META_W-1:0] meta);
        drive_cycle(1'b1, addr, meta, 1'b0, 0);
    endtask

    task automatic respond(input int tag);
        drive_cycle(1'b0, '0, '0, 1'b1, tag);
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, '0, 1'b0, 0);
    endtask

    task automatic single_request_flow();
        @(negedge clk);
        check_value("idle", 32'(idle), 32'd1);
        check_value("bank_full", 32'(bank_full), 32'd0);
        check_value("mem_req_valid", 32'(mem_req_valid), 32'd0);
        check_value("req_drop", 32'(req_drop), 32'd0);
        check_value("rsp_valid", 32'(rsp_valid), 32'd0);
        request(16'h1232, 8'h5a);
        idle_cycle();
        check_value("mem_req_tag.bank", 32'(mem_req_tag.fields.bank), 32'd2);
        check_value("mem_req_tag.slot", 32'(mem_req_tag.fields.slot), 32'd0);
        respond(2 * SLOTS);
        idle_cycle();
        check_value("rsp_meta", 32'(rsp_meta), 32'h5a);
        check_value("idle", 32'(idle), 32'd1);
    endtask

    task automatic fill_bank();
        for (int i = 0; i < SLOTS; i++) begin
            request(ADDR_W'(i * 16 + 1), META_W'(16 + i));
        end
        request(16'h0041, 8'hee); // the ninth finds bank 1 full.
        request(16'h0100, 8'h20);
        request(16'h0202, 8'h21);
        request(16'h0303, 8'h22);
        idle_cycle();
        check_value("bank_full[1]", 32'(bank_full[1]), 32'd1);
    endtask

    task automatic reverse_responses();
        respond(SLOTS + 7);
        idle_cycle();
        check_value("bank_full[1]", 32'(bank_full[1]), 32'd0);
        for (int s = 6; s >= 4; s--) begin
            respond(SLOTS + s);
        end
        request(16'h0051, 8'h77);
        idle_cycle();
        check_value("mem_req_tag.slot", 32'(mem_req_tag.fields.slot), 32'd4);
        for (int s = 4; s >= 0; s--) begin
            respond(SLOTS + s);
        end
    endtask

    task automatic random_traffic();
        logic              do_req;
        logic              do_rsp;
        logic [ADDR_W-1:0] addr;
        logic [META_W-1:0] meta;
        int                ready;
        int                tag;
        drops = 0;
        for (int i = 0; i < RAND_CYCLES; i++) begin
            do_req = random_bits(2) != 0;
            addr   = ADDR_W'(random_bits(ADDR_W));
            meta   = META_W'(random_bits(META_W));
            ready  = count_ready();
            do_rsp = (ready > 0) && (random_bits(1) == 1);
            tag    = 0;
            if (do_rsp) begin
                tag = pick_ready(int'(random_bits(5)) % ready);
            end
            drive_cycle(do_req, addr, meta, do_rsp, tag);
        end
        if (drops == 0) begin
            $display("random traffic never filled a bank, so no drop was exercised");
            stop_on_failure();
        end
    endtask

    task automatic drain_outstanding();
        while (count_open() > 0) begin
            if (count_ready() > 0) begin
                respond(pick_ready(0));
            end else begin
                idle_cycle();
            end
        end
        idle_cycle();
        check_value("idle", 32'(idle), 32'd1);
        check_value("bank_full", 32'(bank_full), 32'd0);
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TEST_CYCLES * 2 * PERIOD);
        $display("watchdog expired, the tests did not finish within %0d cycles", 2 * TEST_CYCLES);
        stop_on_failure();
    end

    initial begin
        drops         = 0;
        lfsr_state    = 16'd6231;
        newest_tag    = -1;
        exp_mem_valid = 1'b0;
        exp_mem_addr  = '0;
        exp_mem_tag   = '0;
        exp_drop      = 1'b0;
        exp_rsp_valid = 1'b0;
        exp_rsp_meta  = '0;
        exp_rsp_data  = '0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            outstanding[t] = 1'b0;
            sb_meta[t]     = '0;
            sb_addr[t]     = '0;
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_count[b] = 0;
        end
        reset           <= 1'b1;
        req_valid       <= 1'b0;
        req_addr        <= '0;
        req_meta        <= '0;
        mem_rsp_valid   <= 1'b0;
        mem_rsp_tag.raw <= '0;
        mem_rsp_data    <= '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        single_request_flow();
        fill_bank();
        reverse_responses();
        random_traffic();
        drain_outstanding();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== sim.f ====
rtl/tag_pkg.sv
rtl/slot_picker.sv
rtl/meta_ram.sv
rtl/index_buffer.sv
rtl/req_dispatch.sv
rtl/rsp_collect.sv
rtl/tag_tracker.sv
sim/tb_tag_tracker.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps -f sim.f --top-module tb_tag_tracker \
    -o tb_tag_tracker > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_tag_tracker > sim.log 2>&1
cat sim.log

grep -q '^\*\*\* PASSED \*\*\*$' sim.log && echo "simulation ok" && exit 0 \
    || { echo "simulation reported failure"; exit 1; }
